/* cps_video.f */
cps_video_pkg.sv
cps_mmr_pkg.sv
cps_mmr.sv
cps_timing.sv
cps_colmix.sv
cps_pal.sv
cps_video.sv
tb_cps_video.sv

/* Bender.yml */
package:
  name: cps_video

sources:
  - cps_video_pkg.sv
  - cps_mmr_pkg.sv
  - cps_mmr.sv
  - cps_timing.sv
  - cps_colmix.sv
  - cps_pal.sv
  - cps_video.sv
  - target: test
    files:
      - tb_cps_video.sv

/* tb_cps_video.sv */
// Testbench for the CPS-1 video colour path
// Random stimulus checked against a cycle model of the register file,
// raster timing, layer mixer and palette stage

module tb_cps_video;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int H_ACTIVE   = 24;
    localparam int H_TOTAL    = 32;
    localparam int HS_START   = 26;
    localparam int HS_END     = 28;
    localparam int V_ACTIVE   = 12;
    localparam int V_TOTAL    = 16;
    localparam int VS_START   = 13;
    localparam int VS_END     = 14;
    localparam int WAIT_LIMIT = 4096;

    // One pixel in flight between the mixer and the palette output
    typedef struct packed {
        logic [11:0] idx;
        logic        hb;
        logic        vb;
    } exp_rec_t;

    logic        clk = 1'b0;
    logic        rst;
    logic        pxl_cen;
    logic [3:0]  gfx_en;
    logic        ppu_cs;
    logic        ppu_wr;
    logic [4:0]  addr;
    logic [15:0] cpu_dout;
    logic [9:0]  scr1_pxl;
    logic [9:0]  scr2_pxl;
    logic [9:0]  scr3_pxl;
    logic [9:0]  obj_pxl;
    logic [15:0] mmr_dout;
    logic [8:0]  hdump;
    logic [8:0]  vdump;
    logic        HS;
    logic        VS;
    logic        HB;
    logic        VB;
    logic        line_start;
    logic        frame_start;
    logic        raster;
    logic [7:0]  red;
    logic [7:0]  green;
    logic [7:0]  blue;
    logic        LHBL_dly;
    logic        LVBL_dly;

    // Model state
    logic [8:0]  m_h;
    logic [8:0]  m_v;
    logic        m_ls;
    logic        m_fs;
    logic        m_rs;
    logic [15:0] m_lc;
    logic [15:0] m_rl;
    logic [15:0] m_dout;
    logic [11:0] m_ptr;
    logic        pend_we;
    logic [11:0] pend_addr;
    logic [11:0] pend_data;
    logic [11:0] m_pal [4096];
    exp_rec_t    pipe [$];
    logic [23:0] e_rgb;
    logic        e_hb;
    logic        e_vb;

    int          errors = 0;
    int          checks = 0;
    int          ls_gap;
    int          fs_gap;
    int          raster_cnt;
    logic        fs_hit;
    logic        timed_out = 1'b0;
    logic        rgb_on = 1'b0;
    logic        rand_pxl = 1'b0;

    always #5 clk = ~clk;

    cps_video #(
        .H_ACTIVE (H_ACTIVE),
        .H_TOTAL  (H_TOTAL),
        .HS_START (HS_START),
        .HS_END   (HS_END),
        .V_ACTIVE (V_ACTIVE),
        .V_TOTAL  (V_TOTAL),
        .VS_START (VS_START),
        .VS_END   (VS_END)
    ) dut_i (
        .clk         (clk),
        .rst         (rst),
        .pxl_cen     (pxl_cen),
        .gfx_en      (gfx_en),
        .ppu_cs      (ppu_cs),
        .ppu_wr      (ppu_wr),
        .addr        (addr),
        .cpu_dout    (cpu_dout),
        .scr1_pxl    (scr1_pxl),
        .scr2_pxl    (scr2_pxl),
        .scr3_pxl    (scr3_pxl),
        .obj_pxl     (obj_pxl),
        .mmr_dout    (mmr_dout),
        .hdump       (hdump),
        .vdump       (vdump),
        .HS          (HS),
        .VS          (VS),
        .HB          (HB),
        .VB          (VB),
        .line_start  (line_start),
        .frame_start (frame_start),
        .raster      (raster),
        .red         (red),
        .green       (green),
        .blue        (blue),
        .LHBL_dly    (LHBL_dly),
        .LVBL_dly    (LVBL_dly)
    );

    task automatic check(input string name, input logic [31:0] act, input logic [31:0] exp);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %0t %s expected %0h actual %0h", $time, name, exp, act);
        end
    endtask

    task automatic finish_run();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        errors++;
        timed_out = 1'b1;
        $display("Timeout while waiting for %s", what);
    endtask

    // Front-most opaque layer with slot 0 first
    function automatic logic [11:0] front_pixel(input logic [15:0] lc, input logic [3:0] en,
                                                input logic [39:0] px);
        logic [1:0] code;
        logic [9:0] p;
        logic       found;
        found = 1'b0;
        front_pixel = 12'd0;
        for (int s = 0; s < 4; s++) begin
            code = lc[2*s +: 2];
            p = px[10*code +: 10];
            if (!found && en[code] && p[3:0] != 4'd15) begin
                front_pixel = {code, p};
                found = 1'b1;
            end
        end
    endfunction

    function automatic logic [23:0] expand(input logic [11:0] w);
        return {w[11:8], w[11:8], w[7:4], w[7:4], w[3:0], w[3:0]};
    endfunction

    // About 30% transparent
    function automatic logic [9:0] rand_pixel();
        logic [5:0] pal;
        logic [3:0] col;
        pal = 6'($urandom);
        col = ($urandom % 10 < 3) ? 4'hf : 4'($urandom % 15);
        return {pal, col};
    endfunction

    task automatic model_reset();
        m_h = '0;
        m_v = '0;
        m_ls = 1'b0;
        m_fs = 1'b0;
        m_rs = 1'b0;
        m_lc = '0;
        m_rl = '0;
        m_dout = '0;
        m_ptr = '0;
        pend_we = 1'b0;
        e_rgb = '0;
        e_hb = 1'b1;
        e_vb = 1'b1;
        ls_gap = 0;
        fs_gap = 0;
        pipe.delete();
        pipe.push_back(exp_rec_t'{12'd0, 1'b1, 1'b1});
    endtask

    // Palette output, mixer sample and counter step of one strobe edge
    task automatic pixel_edge();
        exp_rec_t r;
        r = pipe.pop_front();
        e_hb = r.hb;
        e_vb = r.vb;
        e_rgb = (r.hb || r.vb) ? 24'd0 : expand(m_pal[r.idx]);
        r.idx = front_pixel(m_lc, gfx_en, {obj_pxl, scr3_pxl, scr2_pxl, scr1_pxl});
        r.hb = (m_h >= H_ACTIVE);
        r.vb = (m_v >= V_ACTIVE);
        pipe.push_back(r);
        if (m_h == H_TOTAL - 1) begin
            m_h = '0;
            m_v = (m_v == V_TOTAL - 1) ? 9'd0 : m_v + 9'd1;
        end else begin
            m_h = m_h + 9'd1;
        end
        m_ls = (m_h == 0);
        m_fs = m_ls && (m_v == 0);
        m_rs = m_ls && m_rl[15] && (m_v == m_rl[8:0]);
    endtask

    task automatic cpu_edge();
        if (ppu_cs && ppu_wr) begin
            case (addr)
                cps_mmr_pkg::REG_LAYER_CTRL:  m_lc = cpu_dout;
                cps_mmr_pkg::REG_RASTER_LINE: m_rl = cpu_dout;
                cps_mmr_pkg::REG_PAL_PTR:     m_ptr = cpu_dout[11:0];
                cps_mmr_pkg::REG_PAL_DATA: begin
                    pend_we = 1'b1;
                    pend_addr = m_ptr;
                    pend_data = cpu_dout[11:0];
                    m_ptr = m_ptr + 12'd1;
                end
                default: ;
            endcase
        end else if (ppu_cs) begin
            case (addr)
                cps_mmr_pkg::REG_LAYER_CTRL:  m_dout = m_lc;
                cps_mmr_pkg::REG_RASTER_LINE: m_dout = m_rl;
                cps_mmr_pkg::REG_PAL_PTR:     m_dout = {4'd0, m_ptr};
                cps_mmr_pkg::REG_PAL_DATA:    m_dout = {4'd0, m_ptr};
                default:                      m_dout = '0;
            endcase
        end
    endtask

    task automatic check_outputs();
        check("hdump", hdump, m_h);
        check("vdump", vdump, m_v);
        check("HB", HB, m_h >= H_ACTIVE);
        check("VB", VB, m_v >= V_ACTIVE);
        check("HS", HS, (m_h >= HS_START) && (m_h < HS_END));
        check("VS", VS, (m_v >= VS_START) && (m_v < VS_END));
        check("line_start", line_start, m_ls);
        check("frame_start", frame_start, m_fs);
        check("raster", raster, m_rs);
        check("LHBL_dly", LHBL_dly, !e_hb);
        check("LVBL_dly", LVBL_dly, !e_vb);
        check("mmr_dout", mmr_dout, m_dout);
        if (rgb_on || e_hb || e_vb) begin
            check("red", red, e_rgb[23:16]);
            check("green", green, e_rgb[15:8]);
            check("blue", blue, e_rgb[7:0]);
        end
    endtask

    // One clk cycle; the model sees the inputs held across the last rising edge
    task automatic tick();
        logic strobe;
        @(negedge clk);
        strobe = pxl_cen;
        fs_hit = 1'b0;
        if (rst) begin
            model_reset();
        end else begin
            if (strobe) begin
                pixel_edge();
            end
            if (pend_we) begin
                m_pal[pend_addr] = pend_data;
            end
            pend_we = 1'b0;
            cpu_edge();
        end
        check_outputs();
        if (!rst && strobe) begin
            ls_gap++;
            fs_gap++;
            if (line_start) begin
                check("line_start period", ls_gap, H_TOTAL);
                ls_gap = 0;
            end
            if (frame_start) begin
                check("frame_start period", fs_gap, H_TOTAL * V_TOTAL);
                fs_gap = 0;
                fs_hit = 1'b1;
            end
            if (raster) begin
                raster_cnt++;
            end
        end
        pxl_cen = ~pxl_cen;
        if (rand_pxl) begin
            scr1_pxl = rand_pixel();
            scr2_pxl = rand_pixel();
            scr3_pxl = rand_pixel();
            obj_pxl  = rand_pixel();
        end
    endtask

    task automatic cpu_write(input logic [4:0] a, input logic [15:0] d);
        ppu_cs = 1'b1;
        ppu_wr = 1'b1;
        addr = a;
        cpu_dout = d;
        tick();
        ppu_cs = 1'b0;
        ppu_wr = 1'b0;
    endtask

    task automatic cpu_read(input logic [4:0] a);
        ppu_cs = 1'b1;
        ppu_wr = 1'b0;
        addr = a;
        tick();
        ppu_cs = 1'b0;
        tick();
    endtask

    task automatic wait_vblank();
        int n;
        n = 0;
        while (!timed_out && !VB && n < WAIT_LIMIT) begin
            tick();
            n++;
        end
        if (!timed_out && !VB) begin
            report_timeout("vertical blank");
        end
    endtask

    task automatic wait_frame_start();
        int n;
        n = 0;
        fs_hit = 1'b0;
        while (!timed_out && !fs_hit && n < WAIT_LIMIT) begin
            tick();
            n++;
        end
        if (!timed_out && !fs_hit) begin
            report_timeout("frame start");
        end
    endtask

    initial begin
        void'($urandom(32'h4a41));
        rst = 1'b1;
        pxl_cen = 1'b0;
        gfx_en = 4'hf;
        ppu_cs = 1'b0;
        ppu_wr = 1'b0;
        addr = '0;
        cpu_dout = '0;
        scr1_pxl = 10'h00f;
        scr2_pxl = 10'h00f;
        scr3_pxl = 10'h00f;
        obj_pxl = 10'h00f;
        raster_cnt = 0;
        repeat (16) tick();
        rst = 1'b0;

        // Register readback including an unmapped address
        cpu_write(cps_mmr_pkg::REG_LAYER_CTRL, 16'($urandom));
        cpu_read(cps_mmr_pkg::REG_LAYER_CTRL);
        cpu_write(cps_mmr_pkg::REG_RASTER_LINE, 16'($urandom));
        cpu_read(cps_mmr_pkg::REG_RASTER_LINE);
        cpu_write(cps_mmr_pkg::REG_PAL_PTR, 16'($urandom));
        cpu_read(cps_mmr_pkg::REG_PAL_DATA);
        cpu_read(5'd9);

        // Whole palette through the auto-incrementing pointer
        cpu_write(cps_mmr_pkg::REG_PAL_PTR, 16'd0);
        for (int i = 0; i < 4096; i++) begin
            cpu_write(cps_mmr_pkg::REG_PAL_DATA, 16'($urandom));
        end
        cpu_read(cps_mmr_pkg::REG_PAL_PTR);
        repeat (4) tick();
        rgb_on = 1'b1;

        // Two frames with all layers transparent
        wait_frame_start();
        wait_frame_start();
        wait_frame_start();

        // Random layers with order and enables changed only in vertical blank
        rand_pxl = 1'b1;
        for (int f = 0; f < 6; f++) begin
            wait_vblank();
            cpu_write(cps_mmr_pkg::REG_LAYER_CTRL, 16'($urandom));
            gfx_en = 4'($urandom);
            wait_frame_start();
        end

        // Raster interrupt enabled on a random line
        wait_vblank();
        cpu_write(cps_mmr_pkg::REG_RASTER_LINE, 16'h8000 | 16'($urandom % V_TOTAL));
        wait_frame_start();
        raster_cnt = 0;
        wait_frame_start();
        wait_frame_start();
        check("raster pulses", raster_cnt, 2);

        // Interrupt disabled
        wait_vblank();
        cpu_write(cps_mmr_pkg::REG_RASTER_LINE, 16'($urandom) & 16'h7fff);
        wait_frame_start();
        raster_cnt = 0;
        wait_frame_start();
        wait_frame_start();
        check("raster pulses", raster_cnt, 0);

        finish_run();
    end

endmodule

/* cps_video.sv */
// CPS-1 style video colour path
// Register file, raster timing, layer mixer and palette output

module cps_video #(
    parameter int H_ACTIVE = 384,
    parameter int H_TOTAL  = 512,
    parameter int HS_START = 448,
    parameter int HS_END   = 480,
    parameter int V_ACTIVE = 224,
    parameter int V_TOTAL  = 262,
    parameter int VS_START = 236,
    parameter int VS_END   = 239
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      pxl_cen,
    input  logic [3:0]                gfx_en,
    input  logic                      ppu_cs,
    input  logic                      ppu_wr,
    input  cps_mmr_pkg::cpu_addr_t    addr,
    input  cps_mmr_pkg::cpu_word_t    cpu_dout,
    input  cps_video_pkg::layer_pxl_t scr1_pxl,
    input  cps_video_pkg::layer_pxl_t scr2_pxl,
    input  cps_video_pkg::layer_pxl_t scr3_pxl,
    input  cps_video_pkg::layer_pxl_t obj_pxl,
    output cps_mmr_pkg::cpu_word_t    mmr_dout,
    output cps_video_pkg::pos_t       hdump,
    output cps_video_pkg::pos_t       vdump,
    output logic                      HS,
    output logic                      VS,
    output logic                      HB,
    output logic                      VB,
    output logic                      line_start,
    output logic                      frame_start,
    output logic                      raster,
    output logic [7:0]                red,
    output logic [7:0]                green,
    output logic [7:0]                blue,
    output logic                      LHBL_dly,
    output logic                      LVBL_dly
);

    cps_mmr_pkg::video_cfg_t    cfg;
    cps_mmr_pkg::pal_wr_t       pal_wr;
    cps_video_pkg::raster_pos_t pos;
    cps_video_pkg::pal_idx_t    pal_idx;
    cps_video_pkg::rgb_t        rgb;
    logic                       blank_h;
    logic                       blank_v;

    cps_mmr u_mmr (
        .clk      (clk),
        .rst      (rst),
        .ppu_cs   (ppu_cs),
        .ppu_wr   (ppu_wr),
        .addr     (addr),
        .cpu_dout (cpu_dout),
        .mmr_dout (mmr_dout),
        .cfg      (cfg),
        .pal_wr   (pal_wr)
    );

    cps_timing #(
        .H_ACTIVE (H_ACTIVE),
        .H_TOTAL  (H_TOTAL),
        .HS_START (HS_START),
        .HS_END   (HS_END),
        .V_ACTIVE (V_ACTIVE),
        .V_TOTAL  (V_TOTAL),
        .VS_START (VS_START),
        .VS_END   (VS_END)
    ) u_timing (
        .clk         (clk),
        .rst         (rst),
        .pxl_cen     (pxl_cen),
        .cfg         (cfg),
        .pos         (pos),
        .HS          (HS),
        .VS          (VS),
        .line_start  (line_start),
        .frame_start (frame_start),
        .raster      (raster)
    );

    cps_colmix u_colmix (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .gfx_en   (gfx_en),
        .cfg      (cfg),
        .pos      (pos),
        .scr1_pxl (scr1_pxl),
        .scr2_pxl (scr2_pxl),
        .scr3_pxl (scr3_pxl),
        .obj_pxl  (obj_pxl),
        .pal_idx  (pal_idx),
        .blank_h  (blank_h),
        .blank_v  (blank_v)
    );

    cps_pal u_pal (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .pal_wr   (pal_wr),
        .pal_idx  (pal_idx),
        .blank_h  (blank_h),
        .blank_v  (blank_v),
        .rgb      (rgb),
        .LHBL_dly (LHBL_dly),
        .LVBL_dly (LVBL_dly)
    );

    assign hdump = pos.hdump;
    assign vdump = pos.vdump;
    assign HB    = pos.hb;
    assign VB    = pos.vb;
    assign red   = rgb.r;
    assign green = rgb.g;
    assign blue  = rgb.b;

endmodule

/* cps_pal.sv */
// Palette stage
// 4096-entry colour RAM with a CPU write port, 4:4:4 to 8:8:8
// expansion and blanking carried alongside the read

module cps_pal (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    pxl_cen,
    input  cps_mmr_pkg::pal_wr_t    pal_wr,
    input  cps_video_pkg::pal_idx_t pal_idx,
    input  logic                    blank_h,
    input  logic                    blank_v,
    output cps_video_pkg::rgb_t     rgb,
    output logic                    LHBL_dly,
    output logic                    LVBL_dly
);

    logic [11:0] pal_ram [4096];
    logic [11:0] rd_word;
    logic        hb_dly;
    logic        vb_dly;

    always_ff @(posedge clk) begin
        if (pal_wr.we) begin
            pal_ram[pal_wr.addr] <= pal_wr.data[11:0];
        end
    end

    // Same-edge write to this entry is not seen until the next read
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            rd_word <= pal_ram[pal_idx];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hb_dly <= 1'b1;
            vb_dly <= 1'b1;
        end else if (pxl_cen) begin
            hb_dly <= blank_h;
            vb_dly <= blank_v;
        end
    end

    // Nibble repeated for full-range 8-bit components
    assign rgb = (hb_dly || vb_dly) ? '0 :
                 '{r: {2{rd_word[11:8]}}, g: {2{rd_word[7:4]}}, b: {2{rd_word[3:0]}}};

    assign LHBL_dly = ~hb_dly;
    assign LVBL_dly = ~vb_dly;

endmodule

/* cps_colmix.sv */
// Layer priority mixer
// Picks the front-most opaque layer following layer_ctrl and
// registers its palette index with the blanking pair

module cps_colmix (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       pxl_cen,
    input  logic [3:0]                 gfx_en,
    input  cps_mmr_pkg::video_cfg_t    cfg,
    input  cps_video_pkg::raster_pos_t pos,
    input  cps_video_pkg::layer_pxl_t  scr1_pxl,
    input  cps_video_pkg::layer_pxl_t  scr2_pxl,
    input  cps_video_pkg::layer_pxl_t  scr3_pxl,
    input  cps_video_pkg::layer_pxl_t  obj_pxl,
    output cps_video_pkg::pal_idx_t    pal_idx,
    output logic                       blank_h,
    output logic                       blank_v
);

    cps_video_pkg::layer_pxl_t layer_pxl [4];
    logic [3:0]                opaque;
    cps_video_pkg::pal_idx_t   mix_idx;

    // Indexed by layer code
    assign layer_pxl[cps_video_pkg::scr1] = scr1_pxl;
    assign layer_pxl[cps_video_pkg::scr2] = scr2_pxl;
    assign layer_pxl[cps_video_pkg::scr3] = scr3_pxl;
    assign layer_pxl[cps_video_pkg::obj]  = obj_pxl;

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            opaque[i] = gfx_en[i] && (layer_pxl[i].color != cps_video_pkg::TRANSPARENT);
        end
    end

    // Walked back to front so the front slot overwrites the rest
    always_comb begin
        cps_video_pkg::layer_id_t id;
        mix_idx = '0;
        for (int s = 3; s >= 0; s--) begin
            id = cps_video_pkg::layer_id_t'(cfg.layer_ctrl[2*s +: 2]);
            if (opaque[id]) begin
                mix_idx = {id, layer_pxl[id]};
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pal_idx <= '0;
            blank_h <= 1'b1;
            blank_v <= 1'b1;
        end else if (pxl_cen) begin
            pal_idx <= mix_idx;
            blank_h <= pos.hb;
            blank_v <= pos.vb;
        end
    end

endmodule

/* cps_timing.sv */
// Raster timing generator
// Pixel and line counters, blanking and sync, line and frame starts
// and the programmable raster-line interrupt

module cps_timing #(
    parameter int H_ACTIVE = 384,
    parameter int H_TOTAL  = 512,
    parameter int HS_START = 448,
    parameter int HS_END   = 480,
    parameter int V_ACTIVE = 224,
    parameter int V_TOTAL  = 262,
    parameter int VS_START = 236,
    parameter int VS_END   = 239
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      pxl_cen,
    input  cps_mmr_pkg::video_cfg_t   cfg,
    output cps_video_pkg::raster_pos_t pos,
    output logic                      HS,
    output logic                      VS,
    output logic                      line_start,
    output logic                      frame_start,
    output logic                      raster
);

    cps_video_pkg::pos_t hcnt;
    cps_video_pkg::pos_t vcnt;
    cps_video_pkg::pos_t h_next;
    cps_video_pkg::pos_t v_next;
    logic                h_wrap;

    assign h_wrap = (hcnt == H_TOTAL - 1);
    assign h_next = h_wrap ? '0 : hcnt + 9'd1;

    always_comb begin
        v_next = vcnt;
        if (h_wrap) begin
            v_next = (vcnt == V_TOTAL - 1) ? '0 : vcnt + 9'd1;
        end
    end

    // Start flags are registered so they line up with the counter value 0
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hcnt        <= '0;
            vcnt        <= '0;
            line_start  <= 1'b0;
            frame_start <= 1'b0;
            raster      <= 1'b0;
        end else if (pxl_cen) begin
            hcnt        <= h_next;
            vcnt        <= v_next;
            line_start  <= (h_next == '0);
            frame_start <= (h_next == '0) && (v_next == '0);
            raster      <= (h_next == '0) && cfg.raster_line[15]
                           && (v_next == cfg.raster_line[8:0]);
        end
    end

    assign HS  = (hcnt >= HS_START) && (hcnt < HS_END);
    assign VS  = (vcnt >= VS_START) && (vcnt < VS_END);
    assign pos = '{hdump: hcnt, vdump: vcnt,
                   hb: (hcnt >= H_ACTIVE), vb: (vcnt >= V_ACTIVE)};

endmodule

/* cps_mmr.sv */
// CPU register file of the video block
// Holds layer order, raster line and palette pointer, with readback
// Palette data writes leave as a one-cycle write request

module cps_mmr (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    ppu_cs,
    input  logic                    ppu_wr,
    input  cps_mmr_pkg::cpu_addr_t  addr,
    input  cps_mmr_pkg::cpu_word_t  cpu_dout,
    output cps_mmr_pkg::cpu_word_t  mmr_dout,
    output cps_mmr_pkg::video_cfg_t cfg,
    output cps_mmr_pkg::pal_wr_t    pal_wr
);

    cps_mmr_pkg::cpu_word_t  layer_ctrl;
    cps_mmr_pkg::cpu_word_t  raster_line;
    cps_video_pkg::pal_idx_t pal_ptr;
    cps_video_pkg::pal_idx_t wr_addr;
    cps_mmr_pkg::cpu_word_t  wr_data;
    logic                    wr_en;
    logic                    pal_wr_hit;

    assign pal_wr_hit = ppu_cs && ppu_wr && (addr == cps_mmr_pkg::REG_PAL_DATA);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            layer_ctrl  <= '0;
            raster_line <= '0;
            pal_ptr     <= '0;
            wr_en       <= 1'b0;
            mmr_dout    <= '0;
        end else begin
            wr_en <= pal_wr_hit;
            if (ppu_cs && ppu_wr) begin
                case (addr)
                    cps_mmr_pkg::REG_LAYER_CTRL:  layer_ctrl  <= cpu_dout;
                    cps_mmr_pkg::REG_RASTER_LINE: raster_line <= cpu_dout;
                    cps_mmr_pkg::REG_PAL_PTR:     pal_ptr     <= cpu_dout[11:0];
                    // Pointer wraps naturally at 4096 entries
                    cps_mmr_pkg::REG_PAL_DATA:    pal_ptr     <= pal_ptr + 12'd1;
                    default: ;
                endcase
            end else if (ppu_cs) begin
                case (addr)
                    cps_mmr_pkg::REG_LAYER_CTRL:  mmr_dout <= layer_ctrl;
                    cps_mmr_pkg::REG_RASTER_LINE: mmr_dout <= raster_line;
                    cps_mmr_pkg::REG_PAL_PTR:     mmr_dout <= {4'd0, pal_ptr};
                    cps_mmr_pkg::REG_PAL_DATA:    mmr_dout <= {4'd0, pal_ptr};
                    default:                      mmr_dout <= '0;
                endcase
            end
        end
    end

    // Write payload captured with the pointer before it steps
    always_ff @(posedge clk) begin
        if (pal_wr_hit) begin
            wr_addr <= pal_ptr;
            wr_data <= cpu_dout;
        end
    end

    assign cfg    = '{layer_ctrl: layer_ctrl, raster_line: raster_line};
    assign pal_wr = '{we: wr_en, addr: wr_addr, data: wr_data};

endmodule

/* cps_mmr_pkg.sv */
// CPS-1 video CPU register map
// Address and data types, configuration and palette write request

package cps_mmr_pkg;

    typedef logic [4:0]  cpu_addr_t;
    typedef logic [15:0] cpu_word_t;

    typedef enum logic [4:0] {
        REG_LAYER_CTRL  = 5'd0,
        REG_RASTER_LINE = 5'd1,
        REG_PAL_PTR     = 5'd2,
        REG_PAL_DATA    = 5'd3
    } reg_addr_e;

    // Four 2-bit layer codes in layer_ctrl with the front slot in bits 1:0
    // Bit 15 of raster_line enables the interrupt and bits 8:0 give the line
    typedef struct packed {
        cpu_word_t layer_ctrl;
        cpu_word_t raster_line;
    } video_cfg_t;

    // Colour word is 4:4:4 in bits 11:0
    typedef struct packed {
        logic                    we;
        cps_video_pkg::pal_idx_t addr;
        cpu_word_t               data;
    } pal_wr_t;

endpackage

/* cps_video_pkg.sv */
// CPS-1 video format types
// Layer pixels, palette indexes, colour and raster position

package cps_video_pkg;

    // 4-bit colour field inside a layer pixel
    typedef logic [3:0] color_t;

    // Colour value that lets the next layer show through
    localparam color_t TRANSPARENT = 4'd15;

    // Palette number above the colour
    typedef struct packed {
        logic [5:0] pal;
        color_t     color;
    } layer_pxl_t;

    // Layer code above a layer pixel
    typedef logic [11:0] pal_idx_t;

    typedef enum logic [1:0] {
        scr1 = 2'd0,
        scr2 = 2'd1,
        scr3 = 2'd2,
        obj  = 2'd3
    } layer_id_t;

    // Raster counter value
    typedef logic [8:0] pos_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    typedef struct packed {
        pos_t hdump;
        pos_t vdump;
        logic hb;
        logic vb;
    } raster_pos_t;

endpackage
